// File: verilog/icache_pkg.sv
// shared types of the instruction cache
// physical address equals virtual address, no MMU in front of the cache
// tags travel as full addresses with the index and offset bits cleared
package icache_pkg;

  localparam int unsigned XLEN = 32;

  // ======================================================================
  // plain vectors
  // ======================================================================
  typedef logic [XLEN-1:0] addr_t;
  typedef logic [XLEN-1:0] instr_t;

  // ======================================================================
  // fetch port
  // ======================================================================
  typedef struct packed {
    addr_t vaddr;
  } fetch_req_t;

  // adef flags a misaligned fetch, instr is zero then
  typedef struct packed {
    addr_t  vaddr;
    instr_t instr;
    logic   adef;
  } fetch_rsp_t;

  // ======================================================================
  // memory read channels
  // ======================================================================
  // line aligned incrementing burst, len is beats minus one
  typedef struct packed {
    addr_t      addr;
    logic [7:0] len;
  } mem_ar_t;

  typedef struct packed {
    instr_t data;
    logic   last;
  } mem_r_t;

endpackage

// File: verilog/sdp_ram.sv
// simple dual port RAM, one write port and one registered read port
// a read of the address being written returns the new data
// contents clear on reset so the valid arrays start empty
`timescale 1ns/100ps

module sdp_ram #(
  parameter int DEPTH = 16,
  parameter int WIDTH = 32
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  logic [WIDTH-1:0]         wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output logic [WIDTH-1:0]         rdata_o
);

  logic [WIDTH-1:0] mem_q [DEPTH];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem_q[i] <= '0;
      end
      rdata_o <= '0;
    end else begin
      if (we_i) begin
        mem_q[waddr_i] <= wdata_i;
      end
      // write first on a same address collision
      if (we_i && waddr_i == raddr_i) begin
        rdata_o <= wdata_i;
      end else begin
        rdata_o <= mem_q[raddr_i];
      end
    end
  end

endmodule

// File: verilog/icache_lookup.sv
// stage 1 tag compare over all ways and word select from the hit line
// purely combinational, the array outputs are already registered
`timescale 1ns/100ps

module icache_lookup #(
  parameter int WAY_NUM    = 4,
  parameter int LINE_WORDS = 4
) (
  input  icache_pkg::addr_t                              tag_i,
  input  icache_pkg::addr_t [WAY_NUM-1:0]                way_tag_i,
  input  logic [WAY_NUM-1:0]                             way_valid_i,
  input  icache_pkg::instr_t [WAY_NUM-1:0][LINE_WORDS-1:0] way_line_i,
  input  logic [$clog2(LINE_WORDS)-1:0]                  offset_i,
  output logic                                           hit_o,
  output logic [$clog2(WAY_NUM)-1:0]                     hit_way_o,
  output icache_pkg::instr_t                             word_o
);

  localparam int WAY_W = $clog2(WAY_NUM);

  logic [WAY_NUM-1:0] match;

  always_comb begin
    match     = '0;
    hit_way_o = '0;
    word_o    = '0;
    for (int w = 0; w < WAY_NUM; w++) begin
      match[w] = way_valid_i[w] && way_tag_i[w] == tag_i;
      if (match[w]) begin
        hit_way_o = WAY_W'(w);
        word_o    = way_line_i[w][offset_i];
      end
    end
    hit_o = |match;

    // a line is only ever filled on a miss, so one set never
    // holds the same tag twice
    assert final ($onehot0(match))
      else $error("icache_lookup: several ways match one tag");
  end

endmodule

// File: verilog/icache_plru.sv
// tree pseudo LRU, WAY_NUM-1 bits per set kept in flops
// bit 0 at a node sends the victim walk to the lower half
// a hit or a fill points the path bits away from the used way
`timescale 1ns/100ps

module icache_plru #(
  parameter int WAY_NUM = 4,
  parameter int SET_NUM = 16
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [$clog2(SET_NUM)-1:0] idx_i,
  input  logic                       hit_i,
  input  logic                       fill_i,
  input  logic [$clog2(WAY_NUM)-1:0] way_i,
  output logic [$clog2(WAY_NUM)-1:0] victim_o
);

  localparam int LVL = $clog2(WAY_NUM);

  logic [WAY_NUM-2:0] tree_q [SET_NUM];
  logic [WAY_NUM-2:0] tree_cur;
  logic [WAY_NUM-2:0] tree_nxt;
  logic [LVL-1:0]     used_way;

  assign tree_cur = tree_q[idx_i];
  // on a fill the used way is the victim itself
  assign used_way = hit_i ? way_i : victim_o;

  // follow the bits from the root, node n has children 2n+1 and 2n+2
  always_comb begin
    int node;
    node = 0;
    for (int l = 0; l < LVL; l++) begin
      victim_o[LVL-1-l] = tree_cur[node];
      node = 2 * node + 1 + int'(tree_cur[node]);
    end
  end

  always_comb begin
    int node;
    node     = 0;
    tree_nxt = tree_cur;
    for (int l = 0; l < LVL; l++) begin
      tree_nxt[node] = ~used_way[LVL-1-l];
      node = 2 * node + 1 + int'(used_way[LVL-1-l]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < SET_NUM; s++) begin
        tree_q[s] <= '0;
      end
    end else if (hit_i || fill_i) begin
      tree_q[idx_i] <= tree_nxt;
    end
  end

endmodule

// File: verilog/icache_refill_buf.sv
// gathers the beats of one burst into a cache line
// word 0 is the first beat, the line is complete on the last beat
// and is presented in that same cycle
`timescale 1ns/100ps

module icache_refill_buf #(
  parameter int LINE_WORDS = 4
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   active_i,
  input  logic                                   beat_i,
  input  icache_pkg::mem_r_t                     r_i,
  output icache_pkg::instr_t [LINE_WORDS-1:0]    line_o,
  output logic                                   line_done_o
);

  localparam int CNT_W = $clog2(LINE_WORDS);
  localparam int BUF_W = (LINE_WORDS - 1) * icache_pkg::XLEN;

  logic [BUF_W-1:0] buf_q;
  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (!active_i) begin
      cnt_q <= '0;
    end else if (beat_i) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // new beats enter at the top and move down one word per beat
  always_ff @(posedge clk) begin
    if (beat_i) begin
      buf_q <= BUF_W'({r_i.data, buf_q} >> icache_pkg::XLEN);
    end
  end

  assign line_o      = {r_i.data, buf_q};
  assign line_done_o = beat_i && cnt_q == CNT_W'(LINE_WORDS - 1);

  // the memory must end the burst exactly at the line length
  a_last_on_line_end: assert property (@(posedge clk) disable iff (!rst_n)
    beat_i |-> r_i.last == (cnt_q == CNT_W'(LINE_WORDS - 1)))
    else $error("icache_refill_buf: last does not match the line length");

endmodule

// File: verilog/icache_ctrl.sv
// stage 1 register, refill FSM and array write control
// one fetch in flight, a hit answers one cycle after its array read
// a flush drops stage 1, a running burst drains without an install
`timescale 1ns/100ps

module icache_ctrl #(
  parameter int WAY_NUM    = 4,
  parameter int SET_NUM    = 16,
  parameter int LINE_WORDS = 4
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         req_valid_i,
  input  icache_pkg::fetch_req_t       req_i,
  output logic                         req_ready_o,
  output logic                         rsp_valid_o,
  output icache_pkg::fetch_rsp_t       rsp_o,
  input  logic                         rsp_ready_i,
  input  logic                         inv_valid_i,
  input  logic [$clog2(SET_NUM)-1:0]   inv_idx_i,
  output logic                         inv_ready_o,
  input  logic                         flush_i,
  output logic                         ar_valid_o,
  output icache_pkg::mem_ar_t          ar_o,
  input  logic                         ar_ready_i,
  input  logic                         r_valid_i,
  input  logic                         r_last_i,
  output logic                         r_ready_o,
  input  logic                         hit_i,
  input  icache_pkg::instr_t           hit_word_i,
  input  logic                         line_done_i,
  input  logic [$clog2(WAY_NUM)-1:0]   victim_i,
  output logic [$clog2(SET_NUM)-1:0]   rd_idx_o,
  output logic [$clog2(SET_NUM)-1:0]   wr_idx_o,
  output logic [WAY_NUM-1:0]           tag_we_o,
  output logic [WAY_NUM-1:0]           valid_we_o,
  output logic                         valid_wdata_o,
  output logic [WAY_NUM-1:0]           data_we_o,
  output icache_pkg::addr_t            wr_tag_o,
  output logic                         plru_hit_o,
  output logic                         plru_fill_o,
  output logic [$clog2(LINE_WORDS)-1:0] s1_offset_o
);

  localparam int WAY_W   = $clog2(WAY_NUM);
  localparam int IDX_LSB = $clog2(LINE_WORDS) + 2;
  localparam int TAG_LSB = IDX_LSB + $clog2(SET_NUM);

  typedef enum logic [1:0] {
    IDLE,
    MISS,
    REFILL
  } state_e;

  state_e                 state_q;
  logic                   s1_valid_q;
  logic                   s1_done_q;
  icache_pkg::fetch_req_t s1_req_q;
  icache_pkg::instr_t     s1_instr_q;

  logic s1_adef, lookup, lk_done, lk_miss;
  logic s1_free, inv_fire, req_fire, fill;

  // ====================================================================
  // stage 1 decisions
  // ====================================================================
  assign s1_adef = |s1_req_q.vaddr[1:0];
  // array outputs belong to the stage 1 set only while nothing has answered yet
  assign lookup  = s1_valid_q && !s1_done_q && state_q == IDLE;
  assign lk_done = lookup && (hit_i || s1_adef);
  assign lk_miss = lookup && !hit_i && !s1_adef;

  assign s1_free     = (!s1_valid_q || (s1_done_q && rsp_ready_i)) && state_q == IDLE;
  // invalidate wins over a fetch in the same cycle
  assign inv_ready_o = s1_free;
  assign req_ready_o = s1_free && !inv_valid_i && !flush_i;
  assign inv_fire    = inv_valid_i && inv_ready_o;
  assign req_fire    = req_valid_i && req_ready_o;

  assign rsp_valid_o = s1_done_q;
  assign rsp_o = '{vaddr: s1_req_q.vaddr, instr: s1_instr_q, adef: s1_adef};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q <= 1'b0;
      s1_done_q  <= 1'b0;
    end else if (flush_i) begin
      s1_valid_q <= 1'b0;
      s1_done_q  <= 1'b0;
    end else if (s1_free) begin
      s1_valid_q <= req_fire;
      s1_done_q  <= 1'b0;
    end else if (lk_done) begin
      s1_done_q  <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      s1_req_q <= req_i;
    end
    if (lk_done) begin
      s1_instr_q <= s1_adef ? '0 : hit_word_i;
    end
  end

  // ====================================================================
  // refill FSM
  // ====================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (lk_miss && !flush_i) state_q <= MISS;
        MISS:    if (ar_ready_i) state_q <= REFILL;
        REFILL:  if (r_valid_i && r_last_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  assign ar_valid_o = state_q == MISS;
  assign ar_o = '{addr: {s1_req_q.vaddr[31:IDX_LSB], {IDX_LSB{1'b0}}},
                  len:  8'(LINE_WORDS - 1)};
  assign r_ready_o  = state_q == REFILL;

  // ====================================================================
  // array control
  // ====================================================================
  // a flushed request leaves s1 empty, so its line is never installed
  assign fill = state_q == REFILL && line_done_i && s1_valid_q;

  assign rd_idx_o      = s1_free ? req_i.vaddr[TAG_LSB-1:IDX_LSB]
                                 : s1_req_q.vaddr[TAG_LSB-1:IDX_LSB];
  assign wr_idx_o      = inv_fire ? inv_idx_i : s1_req_q.vaddr[TAG_LSB-1:IDX_LSB];
  assign valid_wdata_o = !inv_fire;
  assign wr_tag_o      = {s1_req_q.vaddr[31:TAG_LSB], {TAG_LSB{1'b0}}};
  assign s1_offset_o   = s1_req_q.vaddr[IDX_LSB-1:2];
  assign plru_hit_o    = lookup && hit_i && !s1_adef;
  assign plru_fill_o   = fill;

  always_comb begin
    for (int i = 0; i < WAY_NUM; i++) begin
      tag_we_o[i]   = fill && victim_i == WAY_W'(i);
      data_we_o[i]  = fill && victim_i == WAY_W'(i);
      // invalidate clears every way of the set
      valid_we_o[i] = inv_fire || tag_we_o[i];
    end
  end

  a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
    else $error("icache_ctrl: AR request dropped or changed before ready");

  a_no_rsp_in_refill: assert property (@(posedge clk) disable iff (!rst_n)
    state_q == REFILL |-> !rsp_valid_o)
    else $error("icache_ctrl: response raised during refill");

endmodule

// File: verilog/icache_top.sv
// set associative instruction cache with a burst refill port
// WAY_NUM and SET_NUM powers of two, LINE_WORDS from 2 to 16
// no write channels and no uncached fetches
`timescale 1ns/100ps

module icache_top #(
  parameter int WAY_NUM    = 4,
  parameter int SET_NUM    = 16,
  parameter int LINE_WORDS = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req_valid_i,
  input  icache_pkg::fetch_req_t     req_i,
  output logic                       req_ready_o,
  output logic                       rsp_valid_o,
  output icache_pkg::fetch_rsp_t     rsp_o,
  input  logic                       rsp_ready_i,
  input  logic                       inv_valid_i,
  input  logic [$clog2(SET_NUM)-1:0] inv_idx_i,
  output logic                       inv_ready_o,
  input  logic                       flush_i,
  output logic                       ar_valid_o,
  output icache_pkg::mem_ar_t        ar_o,
  input  logic                       ar_ready_i,
  input  logic                       r_valid_i,
  input  icache_pkg::mem_r_t         r_i,
  output logic                       r_ready_o
);

  localparam int IDX_W = $clog2(SET_NUM);
  localparam int WAY_W = $clog2(WAY_NUM);
  localparam int OFS_W = $clog2(LINE_WORDS);

  logic [IDX_W-1:0]   rd_idx, wr_idx;
  logic [WAY_NUM-1:0] tag_we, valid_we, data_we;
  logic               valid_wdata;
  icache_pkg::addr_t  wr_tag;
  logic               hit, line_done, plru_hit, plru_fill;
  logic [WAY_W-1:0]   hit_way, victim;
  logic [OFS_W-1:0]   s1_offset;
  icache_pkg::instr_t hit_word;

  icache_pkg::instr_t [LINE_WORDS-1:0]              refill_line;
  icache_pkg::addr_t  [WAY_NUM-1:0]                 way_tag;
  logic               [WAY_NUM-1:0]                 way_valid;
  icache_pkg::instr_t [WAY_NUM-1:0][LINE_WORDS-1:0] way_line;

  icache_ctrl #(
    .WAY_NUM(WAY_NUM), .SET_NUM(SET_NUM), .LINE_WORDS(LINE_WORDS)
  ) u_ctrl (
    .clk, .rst_n, .req_valid_i, .req_i, .req_ready_o, .rsp_valid_o, .rsp_o,
    .rsp_ready_i, .inv_valid_i, .inv_idx_i, .inv_ready_o, .flush_i,
    .ar_valid_o, .ar_o, .ar_ready_i, .r_valid_i, .r_last_i(r_i.last), .r_ready_o,
    .hit_i(hit), .hit_word_i(hit_word), .line_done_i(line_done), .victim_i(victim),
    .rd_idx_o(rd_idx), .wr_idx_o(wr_idx), .tag_we_o(tag_we), .valid_we_o(valid_we),
    .valid_wdata_o(valid_wdata), .data_we_o(data_we), .wr_tag_o(wr_tag),
    .plru_hit_o(plru_hit), .plru_fill_o(plru_fill), .s1_offset_o(s1_offset)
  );

  // ====================================================================
  // per way arrays
  // ====================================================================
  for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
    sdp_ram #(.DEPTH(SET_NUM), .WIDTH(LINE_WORDS * icache_pkg::XLEN)) u_data (
      .clk, .rst_n, .we_i(data_we[w]), .waddr_i(wr_idx), .wdata_i(refill_line),
      .raddr_i(rd_idx), .rdata_o(way_line[w])
    );
    sdp_ram #(.DEPTH(SET_NUM), .WIDTH(icache_pkg::XLEN)) u_tag (
      .clk, .rst_n, .we_i(tag_we[w]), .waddr_i(wr_idx), .wdata_i(wr_tag),
      .raddr_i(rd_idx), .rdata_o(way_tag[w])
    );
    sdp_ram #(.DEPTH(SET_NUM), .WIDTH(1)) u_valid (
      .clk, .rst_n, .we_i(valid_we[w]), .waddr_i(wr_idx), .wdata_i(valid_wdata),
      .raddr_i(rd_idx), .rdata_o(way_valid[w])
    );
  end

  // ====================================================================
  // datapath
  // ====================================================================
  icache_lookup #(.WAY_NUM(WAY_NUM), .LINE_WORDS(LINE_WORDS)) u_lookup (
    .tag_i(wr_tag), .way_tag_i(way_tag), .way_valid_i(way_valid),
    .way_line_i(way_line), .offset_i(s1_offset),
    .hit_o(hit), .hit_way_o(hit_way), .word_o(hit_word)
  );

  // stage 1 set index comes through the write index outside invalidates
  icache_plru #(.WAY_NUM(WAY_NUM), .SET_NUM(SET_NUM)) u_plru (
    .clk, .rst_n, .idx_i(wr_idx), .hit_i(plru_hit), .fill_i(plru_fill),
    .way_i(hit_way), .victim_o(victim)
  );

  icache_refill_buf #(.LINE_WORDS(LINE_WORDS)) u_refill_buf (
    .clk, .rst_n, .active_i(r_ready_o), .beat_i(r_valid_i && r_ready_o),
    .r_i, .line_o(refill_line), .line_done_o(line_done)
  );

endmodule

// File: tests/tb_icache_mem.sv
// behavioral burst memory for the icache testbench
// word at byte address A reads as A ^ 32'hC0DE0000
// ar_ready and r_valid stall at random, one burst at a time
`timescale 1ns/100ps

module tb_icache_mem (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      ar_valid_i,
  input  icache_pkg::mem_ar_t       ar_i,
  output logic                      ar_ready_o,
  output logic                      r_valid_o,
  output icache_pkg::mem_r_t        r_o,
  input  logic                      r_ready_i
);

  logic              busy_q;
  logic              pending_q;
  icache_pkg::addr_t addr_q;
  int                left_q;

  // quiet bus until the first falling edge
  initial begin
    ar_ready_o <= 1'b0;
    r_valid_o  <= 1'b0;
    r_o        <= '0;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q    <= 1'b0;
      pending_q <= 1'b0;
      addr_q    <= '0;
      left_q    <= 0;
    end else begin
      if (ar_valid_i && ar_ready_o) begin
        busy_q <= 1'b1;
        addr_q <= ar_i.addr;
        left_q <= int'(ar_i.len) + 1;
      end
      // a beat offered and not taken must stay offered
      pending_q <= r_valid_o && !r_ready_i;
      if (r_valid_o && r_ready_i) begin
        addr_q <= addr_q + 32'd4;
        left_q <= left_q - 1;
        if (left_q == 1) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  always @(negedge clk) begin
    ar_ready_o <= !busy_q && ar_valid_i && ($urandom % 4 != 0);
    r_valid_o  <= busy_q && (pending_q || ($urandom % 3 != 0));
    r_o.data   <= addr_q ^ 32'hC0DE0000;
    r_o.last   <= left_q == 1;
  end

endmodule

// File: tests/tb_icache.sv
// icache testbench, random and directed fetches against a residency model
// addresses use tags 0..7 so the model indexes lines by addr[10:8]
// geometry is 4 ways, 16 sets, 4 words per line
`timescale 1ns/100ps

module tb_icache;

  localparam int NUM_OPS = 300;
  localparam int REFILL_WORST = 120;
  localparam int WATCHDOG_NS = (NUM_OPS + 60) * REFILL_WORST * 40;
  localparam int AR_NO = 0;
  localparam int AR_YES = 1;
  localparam int AR_ANY = 2;

  logic clk = 1'b0;
  logic rst_n, req_valid_i, rsp_ready_i, inv_valid_i, flush_i;
  logic req_ready_o, rsp_valid_o, inv_ready_o, ar_valid_o, ar_ready_i;
  logic r_valid_i, r_ready_o;
  logic [3:0] inv_idx_i;
  icache_pkg::fetch_req_t req_i;
  icache_pkg::fetch_rsp_t rsp_o;
  icache_pkg::mem_ar_t    ar_o;
  icache_pkg::mem_r_t     r_i;

  string test_name = "reset";
  int    forced_ar = -1;
  int    ar_cnt = 0;

  icache_pkg::fetch_rsp_t exp_rsp_q [$];
  int                     exp_ar_q [$];
  int                     base_q [$];

  // bus tracking for the r_ready and back-pressure checks
  logic                   refill_exp = 1'b0;
  logic                   hold_exp = 1'b0;
  icache_pkg::fetch_rsp_t held_rsp;

  // residency model, a line may be present only after its refill answered
  logic res_q [16][8];
  int   cnt_q [16];
  int   mru_q [16];

  icache_top #(.WAY_NUM(4), .SET_NUM(16), .LINE_WORDS(4)) dut0 (.*);

  tb_icache_mem u_mem (
    .clk, .rst_n, .ar_valid_i(ar_valid_o), .ar_i(ar_o), .ar_ready_o(ar_ready_i),
    .r_valid_o(r_valid_i), .r_o(r_i), .r_ready_i(r_ready_o)
  );

  always #20 clk = ~clk;

  // ======================================================================
  // failure reporting and compare tasks
  // ======================================================================
  task automatic report_failure(string msg);
    $display("%s in test %s", msg, test_name);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_rsp(icache_pkg::fetch_rsp_t exp, icache_pkg::fetch_rsp_t act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", test_name, exp, act);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  task automatic check_ar(icache_pkg::mem_ar_t exp, icache_pkg::mem_ar_t act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", test_name, exp, act);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  task automatic check_flag(string what, logic exp, logic act);
    if (exp !== act) begin
      $display("ERR %s %s expected %b actual %b", test_name, what, exp, act);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  function automatic icache_pkg::addr_t line_addr(int tag, int set, int word);
    return icache_pkg::addr_t'((tag << 8) | (set << 4) | (word << 2));
  endfunction

  function automatic int predict_ar(icache_pkg::addr_t a);
    int s;
    int t;
    s = int'(a[7:4]);
    t = int'(a[10:8]);
    if (a[1:0] != 2'b00) return AR_NO;
    if (!res_q[s][t]) return AR_YES;
    // two fills after an invalidate never evict each other, nor is the MRU line evicted
    if (cnt_q[s] <= 2 || mru_q[s] == t) return AR_NO;
    return AR_ANY;
  endfunction

  // ======================================================================
  // monitor and model update
  // ======================================================================
  always @(posedge clk) begin
    icache_pkg::fetch_rsp_t exp;
    icache_pkg::mem_ar_t    exp_ar;
    int delta;
    int s;
    int t;
    if (rst_n) begin
      // r_ready spans the burst from the accepted AR to the last beat
      check_flag("r_ready_o", refill_exp, r_ready_o);
      if (hold_exp) begin
        check_flag("rsp_valid_o", 1'b1, rsp_valid_o);
        check_rsp(held_rsp, rsp_o);
      end
      // a stalled response stays put until it is taken
      hold_exp = rsp_valid_o && !rsp_ready_i && !flush_i;
      held_rsp = rsp_o;
      if (flush_i) begin
        exp_rsp_q.delete();
        exp_ar_q.delete();
        base_q.delete();
      end
      if (ar_valid_o && ar_ready_i) begin
        refill_exp = 1'b1;
        if (exp_rsp_q.size() == 0) begin
          report_failure("burst request with no fetch outstanding");
        end else begin
          exp_ar.addr = {exp_rsp_q[0].vaddr[31:4], 4'h0};
          exp_ar.len  = 8'd3;
          check_ar(exp_ar, ar_o);
          ar_cnt++;
        end
      end
      if (r_valid_i && r_ready_o && r_i.last) begin
        refill_exp = 1'b0;
      end
      if (rsp_valid_o && rsp_ready_i) begin
        if (exp_rsp_q.size() == 0) begin
          report_failure("response with no fetch outstanding");
        end else begin
          check_rsp(exp_rsp_q[0], rsp_o);
          delta = ar_cnt - base_q[0];
          if (delta > 1 || (exp_ar_q[0] == AR_NO && delta != 0) ||
              (exp_ar_q[0] == AR_YES && delta != 1)) begin
            report_failure($sformatf("fetch %h made %0d burst requests", rsp_o.vaddr, delta));
          end else begin
            s = int'(rsp_o.vaddr[7:4]);
            t = int'(rsp_o.vaddr[10:8]);
            if (!rsp_o.adef) begin
              if (delta == 1 && !res_q[s][t]) begin
                res_q[s][t] = 1'b1;
                cnt_q[s]++;
              end
              mru_q[s] = t;
            end
            void'(exp_rsp_q.pop_front());
            void'(exp_ar_q.pop_front());
            void'(base_q.pop_front());
          end
        end
      end
      if (inv_valid_i && inv_ready_o) begin
        for (int i = 0; i < 8; i++) res_q[inv_idx_i][i] = 1'b0;
        cnt_q[inv_idx_i] = 0;
        mru_q[inv_idx_i] = -1;
      end
      if (req_valid_i && req_ready_o) begin
        exp.vaddr = req_i.vaddr;
        exp.adef  = |req_i.vaddr[1:0];
        exp.instr = exp.adef ? '0 : (req_i.vaddr ^ 32'hC0DE0000);
        exp_rsp_q.push_back(exp);
        exp_ar_q.push_back(forced_ar >= 0 ? forced_ar : predict_ar(req_i.vaddr));
        base_q.push_back(ar_cnt);
      end
    end
  end

  // ======================================================================
  // drivers
  // ======================================================================
  task automatic fetch(icache_pkg::addr_t a, int force_ar);
    @(negedge clk);
    forced_ar   = force_ar;
    req_valid_i = 1'b1;
    req_i.vaddr = a;
    @(posedge clk);
    while (!req_ready_o) @(posedge clk);
    @(negedge clk);
    req_valid_i = 1'b0;
  endtask

  task automatic invalidate(int idx);
    @(negedge clk);
    inv_valid_i = 1'b1;
    inv_idx_i   = 4'(idx);
    @(posedge clk);
    while (!inv_ready_o) @(posedge clk);
    @(negedge clk);
    inv_valid_i = 1'b0;
  endtask

  task automatic drain();
    while (exp_rsp_q.size() != 0) @(posedge clk);
  endtask

  always @(negedge clk) begin
    rsp_ready_i = ($urandom % 4) != 0;
  end

  initial begin
    #(WATCHDOG_NS);
    report_failure("watchdog expired before the tests finished");
  end

  initial begin
    void'($urandom(32'h5123e2b8));
    rst_n = 1'b0;
    req_valid_i = 1'b0;
    req_i = '0;
    rsp_ready_i = 1'b0;
    inv_valid_i = 1'b0;
    inv_idx_i = '0;
    flush_i = 1'b0;
    for (int s = 0; s < 16; s++) begin
      for (int t = 0; t < 8; t++) res_q[s][t] = 1'b0;
      cnt_q[s] = 0;
      mru_q[s] = -1;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_name = "miss_then_hit";
    invalidate(5);
    fetch(line_addr(1, 5, 2), AR_YES);
    fetch(line_addr(1, 5, 2), AR_NO);
    fetch(line_addr(1, 5, 3), AR_NO);
    drain();

    test_name = "misaligned";
    fetch(line_addr(2, 9, 1) | 32'd2, AR_NO);
    drain();

    test_name = "invalidate";
    invalidate(5);
    fetch(line_addr(1, 5, 0), AR_YES);
    drain();

    test_name = "flush_refill";
    invalidate(6);
    fetch(line_addr(3, 6, 1), AR_YES);
    while (!r_ready_o) @(posedge clk);
    @(negedge clk);
    flush_i = 1'b1;
    @(negedge clk);
    flush_i = 1'b0;
    fetch(line_addr(3, 6, 1), AR_YES);
    drain();

    test_name = "set_overflow";
    invalidate(7);
    for (int t = 0; t < 5; t++) fetch(line_addr(t, 7, t % 4), AR_YES);
    for (int i = 0; i < 20; i++) fetch(line_addr($urandom % 5, 7, $urandom % 4), -1);
    drain();

    test_name = "random";
    for (int i = 0; i < NUM_OPS; i++) begin
      if ($urandom % 40 == 0) begin
        invalidate($urandom % 4);
      end else if ($urandom % 16 == 0) begin
        fetch(line_addr($urandom % 6, $urandom % 4, $urandom % 4) | (1 + $urandom % 3), -1);
      end else begin
        fetch(line_addr($urandom % 6, $urandom % 4, $urandom % 4), -1);
      end
      if ($urandom % 5 == 0) repeat ($urandom % 3) @(negedge clk);
    end
    drain();

    $display("Everything OK");
    $finish;
  end

endmodule

// File: build.f
verilog/icache_pkg.sv
verilog/sdp_ram.sv
verilog/icache_lookup.sv
verilog/icache_plru.sv
verilog/icache_refill_buf.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
tests/tb_icache_mem.sv
tests/tb_icache.sv

// File: run_sim.sh
#!/bin/sh
# builds the icache testbench with Verilator and runs it
# the result is decided by the pass line in the log

LOG=sim.log

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_icache \
  -o sim_icache
status=$?
if [ $status -ne 0 ]; then
  echo "compile step failed with status $status"
  exit 1
fi

./obj_dir/sim_icache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
fi

if grep -q "^Everything OK$" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation did not pass, see $LOG"
  exit 1
fi
